//--- logic/cam_qspi_pkg.sv
/* Shared widths, frame buffer sizes, QSPI command constants,
   status bit positions and the burst writer state encoding */
package cam_qspi_pkg;

	// --------------------
	// Data path widths
	localparam int unsigned data_w         = 32;  // Bus and buffer word
	localparam int unsigned byte_w         = 8;   // Camera byte
	localparam int unsigned bytes_per_word = 4;   // Bytes packed per word

	// --------------------
	// Frame buffer geometry
	localparam int unsigned bank_words = 512;                   // Words per bank
	localparam int unsigned bank_aw    = $clog2(bank_words);    // 9 bits
	localparam int unsigned fb_aw      = bank_aw + 1;           // Two banks, top bit is bank

	// --------------------
	// QSPI SRAM side
	localparam int unsigned burst_bytes     = 512;  // One Quad Write burst
	localparam int unsigned bursts_per_bank =
		bank_words * bytes_per_word / burst_bytes;   // 4 bursts drain a bank
	localparam int unsigned qspi_aw         = 24;   // SRAM byte address
	localparam int unsigned qspi_cmd_w      = 8;

	localparam logic [qspi_cmd_w-1:0] qpi_wr_cmd      = 8'h38;        // Quad Write
	localparam logic [qspi_aw-1:0]    qspi_start_addr = 24'h000004;   // First burst

	// --------------------
	// Host register fields
	localparam logic [1:0]  ctrl_stream_code = 2'b10;  // Low control bits, stream on
	localparam int unsigned sts_vsync_bit    = 8;
	localparam int unsigned sts_bank_bit     = 0;

	// Burst writer states
	typedef enum logic [2:0] {
		st_idle,       // Waiting for enable and a full bank
		st_cmd,        // Command bits on dat[0]
		st_addr,       // Six address nibbles
		st_data,       // 128 words, eight nibbles each
		st_desel,      // First ncs high cycle
		st_gap,        // Second ncs high cycle, next burst decision
		st_bank_wait   // Bank drained, wait for camera to move on
	} qspi_state_e;

endpackage

//--- logic/bank_ram.sv
/* One 512x32 simple dual-port memory bank,
   synchronous write and registered read */
`timescale 1ns/1ns

module bank_ram (
	input  logic                                WBs_CLK_i,
	input  logic                                wr_en_i,
	input  logic [cam_qspi_pkg::bank_aw-1:0]    wr_addr_i,
	input  logic [cam_qspi_pkg::data_w-1:0]     wr_data_i,
	input  logic [cam_qspi_pkg::bank_aw-1:0]    rd_addr_i,
	output logic [cam_qspi_pkg::data_w-1:0]     rd_data_o
);
	import cam_qspi_pkg::*;

	logic [data_w-1:0] mem [bank_words];  // Block RAM array

	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;  // Write port
		end
		rd_data_o <= mem[rd_addr_i];      // Read data one cycle later
	end

endmodule

//--- logic/frame_buffer.sv
/* Ping-pong frame buffer of two memory banks with
   bank-steered write and registered read select */
`timescale 1ns/1ns

module frame_buffer (
	input  logic                               WBs_CLK_i,
	input  logic                               wr_en_i,
	input  logic [cam_qspi_pkg::fb_aw-1:0]     wr_addr_i,
	input  logic [cam_qspi_pkg::data_w-1:0]    wr_data_i,
	input  logic [cam_qspi_pkg::fb_aw-1:0]     rd_addr_i,
	output logic [cam_qspi_pkg::data_w-1:0]    rd_data_o
);
	import cam_qspi_pkg::*;

	logic [data_w-1:0] bank_rd [2];  // Per-bank read data
	logic              rd_bank_q;    // Bank of the read in flight

	// --------------------
	// Banks
	for (genvar b = 0; b < 2; b++) begin : g_bank
		bank_ram bank_i (
			.WBs_CLK_i (WBs_CLK_i),
			.wr_en_i   (wr_en_i && (wr_addr_i[fb_aw-1] == 1'(b))),  // Top bit steers
			.wr_addr_i (wr_addr_i[bank_aw-1:0]),
			.wr_data_i (wr_data_i),
			.rd_addr_i (rd_addr_i[bank_aw-1:0]),
			.rd_data_o (bank_rd[b])
		);
	end

	// Select lines up with the registered read
	always_ff @(posedge WBs_CLK_i) begin
		rd_bank_q <= rd_addr_i[fb_aw-1];
	end

	assign rd_data_o = bank_rd[rd_bank_q];  // Output mux

endmodule

//--- logic/cam_pixel_packer.sv
/* Camera byte packer, four gated bytes per word,
   with the wrapping frame buffer write address */
`timescale 1ns/1ns

module cam_pixel_packer (
	input  logic                               WBs_CLK_i,
	input  logic                               WBs_RST_i,
	input  logic                               cam_pix_stb_i,
	input  logic                               cam_href_i,
	input  logic                               cam_vsync_i,
	input  logic [cam_qspi_pkg::byte_w-1:0]    cam_dat_i,
	output logic                               wr_en_o,
	output logic [cam_qspi_pkg::fb_aw-1:0]     wr_addr_o,
	output logic [cam_qspi_pkg::data_w-1:0]    wr_data_o
);
	import cam_qspi_pkg::*;

	logic                              byte_ok;   // Byte accepted this edge
	logic                              last_byte; // Fourth byte of a word
	logic [$clog2(bytes_per_word)-1:0] phase_q;   // Bytes held so far
	logic [data_w-byte_w-1:0]          acc_q;     // First three bytes

	assign byte_ok   = cam_pix_stb_i & cam_href_i & cam_vsync_i;  // Line and frame gate
	assign last_byte = (phase_q == $clog2(bytes_per_word)'(bytes_per_word - 1));

	// --------------------
	// Control state
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase_q   <= '0;
			wr_en_o   <= 1'b0;
			wr_addr_o <= '0;
		end else begin
			wr_en_o <= byte_ok & last_byte;   // One-cycle write pulse
			if (byte_ok) begin
				phase_q <= phase_q + 1'b1;    // Wraps after four, held over gaps
			end
			if (wr_en_o) begin
				wr_addr_o <= wr_addr_o + 1'b1;  // Modulo two banks
			end
		end
	end

	// Payload shift, first byte ends up on top
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_ok) begin
			if (last_byte) begin
				wr_data_o <= {acc_q, cam_dat_i};
			end else begin
				acc_q <= {acc_q[data_w-2*byte_w-1:0], cam_dat_i};
			end
		end
	end

endmodule

//--- logic/qspi_burst_writer.sv
/* Ping-pong bank streamer sending Quad Write bursts
   of command, address and data nibbles to a QSPI SRAM */
`timescale 1ns/1ns

module qspi_burst_writer (
	input  logic                               WBs_CLK_i,
	input  logic                               WBs_RST_i,
	input  logic                               stream_en_i,
	input  logic                               cam_bank_i,
	output logic [cam_qspi_pkg::fb_aw-1:0]     rd_addr_o,
	input  logic [cam_qspi_pkg::data_w-1:0]    rd_data_i,
	output logic                               quad_ncs_o,
	output logic [3:0]                         quad_dat_o
);
	import cam_qspi_pkg::*;

	qspi_state_e                                      state_q;
	logic [data_w-1:0]                                sh_q;        // Cmd, addr or data shifter
	logic [2:0]                                       cnt_q;       // Bit or nibble in phase
	logic [$clog2(burst_bytes/bytes_per_word)-1:0]    wcnt_q;      // Word in burst
	logic [$clog2(bursts_per_bank)-1:0]               bcnt_q;      // Burst in bank
	logic [qspi_aw-1:0]                               next_addr_q; // SRAM address of next burst
	logic                                             bank_ready;  // Camera left the read bank
	logic                                             burst_go;

	// Read bank is full once the camera writes the other one
	assign bank_ready = (cam_bank_i != rd_addr_o[fb_aw-1]);

	// --------------------
	// Burst start decision
	always_comb begin
		case (state_q)
			st_idle, st_bank_wait: burst_go = stream_en_i & bank_ready;
			st_gap:                burst_go = stream_en_i & (bcnt_q != '0);  // Bank not done
			default:               burst_go = 1'b0;
		endcase
	end

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state_q     <= st_idle;
			sh_q        <= '0;
			cnt_q       <= '0;
			wcnt_q      <= '0;
			bcnt_q      <= '0;
			next_addr_q <= qspi_start_addr;
			rd_addr_o   <= '0;
			quad_ncs_o  <= 1'b1;
			quad_dat_o  <= 4'h0;
		end else begin
			case (state_q)
				// --------------------
				// Waiting between bursts
				st_idle, st_gap, st_bank_wait: begin
					if (burst_go) begin
						quad_ncs_o <= 1'b0;                              // Select SRAM
						quad_dat_o <= {3'b000, qpi_wr_cmd[qspi_cmd_w-1]}; // Cmd MSB
						sh_q       <= {qpi_wr_cmd[qspi_cmd_w-2:0],
						               {(data_w-qspi_cmd_w+1){1'b0}}};
						cnt_q      <= '0;
						state_q    <= st_cmd;
					end else if (state_q == st_gap) begin
						// Drained bank or streaming switched off
						state_q <= (bcnt_q == '0) ? st_bank_wait : st_idle;
					end
				end

				// Serial command on dat[0]
				st_cmd: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 3'd7) begin
						quad_dat_o  <= next_addr_q[qspi_aw-1 -: 4];   // First addr nibble
						sh_q        <= {next_addr_q[qspi_aw-5:0],
						                {(data_w-qspi_aw+4){1'b0}}};
						next_addr_q <= next_addr_q + qspi_aw'(burst_bytes);  // 24-bit wrap
						cnt_q       <= '0;
						state_q     <= st_addr;
					end else begin
						quad_dat_o <= {3'b000, sh_q[data_w-1]};
						sh_q       <= {sh_q[data_w-2:0], 1'b0};
					end
				end

				st_addr: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == 3'd5) begin
						quad_dat_o <= rd_data_i[data_w-1 -: 4];      // First word already read
						sh_q       <= {rd_data_i[data_w-5:0], 4'h0};
						cnt_q      <= '0;
						state_q    <= st_data;
					end else begin
						quad_dat_o <= sh_q[data_w-1 -: 4];
						sh_q       <= {sh_q[data_w-5:0], 4'h0};
					end
				end

				// --------------------
				// Data nibbles, MSB first
				st_data: begin
					cnt_q <= cnt_q + 1'b1;                   // Wraps per word
					if (cnt_q == 3'd5) begin
						rd_addr_o <= rd_addr_o + 1'b1;       // Prefetch, lands by nibble 7
					end
					if (cnt_q == 3'd7) begin
						wcnt_q <= wcnt_q + 1'b1;
						if (&wcnt_q) begin
							quad_ncs_o <= 1'b1;              // End of 512 bytes
							quad_dat_o <= 4'h0;
							bcnt_q     <= bcnt_q + 1'b1;     // Zero again after last burst
							state_q    <= st_desel;
						end else begin
							quad_dat_o <= rd_data_i[data_w-1 -: 4];
							sh_q       <= {rd_data_i[data_w-5:0], 4'h0};
						end
					end else begin
						quad_dat_o <= sh_q[data_w-1 -: 4];
						sh_q       <= {sh_q[data_w-5:0], 4'h0};
					end
				end

				st_desel: state_q <= st_gap;  // Keep ncs high two cycles

				default: begin
					quad_ncs_o <= 1'b1;
					state_q    <= st_idle;
				end
			endcase
		end
	end

endmodule

//--- logic/wb_ctrl_regs.sv
/* Host bus slave with single-cycle ack,
   control register and status readback */
`timescale 1ns/1ns

module wb_ctrl_regs (
	input  logic                               WBs_CLK_i,
	input  logic                               WBs_RST_i,
	input  logic                               wbs_cyc_i,
	input  logic                               wbs_stb_i,
	input  logic                               wbs_we_i,
	input  logic [cam_qspi_pkg::data_w-1:0]    wbs_dat_i,
	input  logic                               cam_vsync_i,
	input  logic                               cam_bank_i,
	output logic                               wbs_ack_o,
	output logic [cam_qspi_pkg::data_w-1:0]    wbs_dat_o,
	output logic                               stream_en_o
);
	import cam_qspi_pkg::*;

	logic                               ack_nxt;  // New access seen
	logic [$bits(ctrl_stream_code)-1:0] ctrl_q;   // Mode bits of the control word

	assign ack_nxt = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;  // Ack drops after one cycle

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o <= 1'b0;
			ctrl_q    <= '0;   // Streaming off
		end else begin
			wbs_ack_o <= ack_nxt;
			if (ack_nxt & wbs_we_i) begin
				ctrl_q <= wbs_dat_i[$bits(ctrl_stream_code)-1:0];  // Capture with ack
			end
		end
	end

	assign stream_en_o = (ctrl_q == ctrl_stream_code);

	// --------------------
	// Status word, other bits zero
	always_comb begin
		wbs_dat_o                = '0;
		wbs_dat_o[sts_vsync_bit] = cam_vsync_i;
		wbs_dat_o[sts_bank_bit]  = cam_bank_i;   // Bank being filled
	end

endmodule

//--- logic/cam_qspi_bridge.sv
/* Camera to QSPI SRAM bridge top level:
   packer, frame buffer, burst writer and host registers */
`timescale 1ns/1ns

module cam_qspi_bridge (
	input  logic                               WBs_CLK_i,
	input  logic                               WBs_RST_i,
	// Host bus
	input  logic                               wbs_cyc_i,
	input  logic                               wbs_stb_i,
	input  logic                               wbs_we_i,
	input  logic [cam_qspi_pkg::data_w-1:0]    wbs_dat_i,
	output logic                               wbs_ack_o,
	output logic [cam_qspi_pkg::data_w-1:0]    wbs_dat_o,
	// Camera
	input  logic                               cam_pix_stb_i,
	input  logic                               cam_href_i,
	input  logic                               cam_vsync_i,
	input  logic [cam_qspi_pkg::byte_w-1:0]    cam_dat_i,
	// QSPI SRAM
	output logic                               quad_ncs_o,
	output logic [3:0]                         quad_dat_o
);
	import cam_qspi_pkg::*;

	logic              wr_en;
	logic [fb_aw-1:0]  wr_addr;
	logic [data_w-1:0] wr_data;
	logic [fb_aw-1:0]  rd_addr;
	logic [data_w-1:0] rd_data;
	logic              cam_bank;    // Bank the camera is filling
	logic              stream_en;

	assign cam_bank = wr_addr[fb_aw-1];

	// --------------------
	cam_pixel_packer packer_i (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.cam_pix_stb_i (cam_pix_stb_i),
		.cam_href_i    (cam_href_i),
		.cam_vsync_i   (cam_vsync_i),
		.cam_dat_i     (cam_dat_i),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.wr_data_o     (wr_data)
	);

	frame_buffer fb_i (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	qspi_burst_writer writer_i (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.stream_en_i (stream_en),
		.cam_bank_i  (cam_bank),
		.rd_addr_o   (rd_addr),
		.rd_data_i   (rd_data),
		.quad_ncs_o  (quad_ncs_o),
		.quad_dat_o  (quad_dat_o)
	);

	wb_ctrl_regs regs_i (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.wbs_cyc_i   (wbs_cyc_i),
		.wbs_stb_i   (wbs_stb_i),
		.wbs_we_i    (wbs_we_i),
		.wbs_dat_i   (wbs_dat_i),
		.cam_vsync_i (cam_vsync_i),
		.cam_bank_i  (cam_bank),
		.wbs_ack_o   (wbs_ack_o),
		.wbs_dat_o   (wbs_dat_o),
		.stream_en_o (stream_en)
	);

endmodule

//--- bench/qspi_sram_model.sv
/* QSPI SRAM side monitor, decodes Quad Write command,
   address and data nibbles and checks every burst */
`timescale 1ns/1ns

module qspi_sram_model (
	input  logic       WBs_CLK_i,
	input  logic       quad_ncs_i,
	input  logic [3:0] quad_dat_i,
	output logic       byte_vld_o,
	output logic [7:0] byte_o,
	output int         burst_cnt_o,
	output int         err_cnt_o
);
	import cam_qspi_pkg::*;

	logic [qspi_cmd_w-1:0] cmd      = '0;               // Shifted command bits
	logic [qspi_aw-1:0]    addr     = '0;               // Shifted address nibbles
	logic [qspi_aw-1:0]    exp_addr = qspi_start_addr;  // Next expected burst address
	logic [3:0]            hi_nib   = '0;               // High half of byte
	logic                  in_burst = 1'b0;
	int                    cyc      = 0;                // Cycles since select
	int                    nbytes   = 0;
	int                    bursts   = 0;
	int                    errs     = 0;

	// Outputs change on the falling edge, stable at the rising one
	always @(negedge WBs_CLK_i) begin
		byte_vld_o <= 1'b0;
		if (quad_ncs_i === 1'b0) begin
			if (!in_burst) begin
				in_burst = 1'b1;  // New burst
				cyc      = 0;
				nbytes   = 0;
			end
			if (cyc < qspi_cmd_w) begin
				assert (quad_dat_i[3:1] == 3'b000) else begin
					$display("Fail quad_dat_o[3:1]: got %h expected %h", quad_dat_i[3:1], 3'h0);
					errs++;
				end
				cmd = {cmd[qspi_cmd_w-2:0], quad_dat_i[0]};  // Serial, MSB first
			end else if (cyc < qspi_cmd_w + qspi_aw / 4) begin
				addr = {addr[qspi_aw-5:0], quad_dat_i};
			end else if (cyc % 2 == 0) begin
				hi_nib = quad_dat_i;                        // High nibble first
			end else begin
				byte_o     <= {hi_nib, quad_dat_i};
				byte_vld_o <= 1'b1;
				nbytes++;
			end
			cyc++;
		end else if (in_burst) begin
			// --------------------
			// Burst closed by ncs high
			in_burst = 1'b0;
			assert (cmd == qpi_wr_cmd) else begin
				$display("Fail quad_dat_o command: got %h expected %h", cmd, qpi_wr_cmd);
				errs++;
			end
			assert (addr == exp_addr) else begin
				$display("Fail quad_dat_o address: got %h expected %h", addr, exp_addr);
				errs++;
			end
			assert (nbytes == burst_bytes) else begin
				$display("Fail quad_dat_o burst bytes: got %h expected %h", nbytes, burst_bytes);
				errs++;
			end
			exp_addr = exp_addr + qspi_aw'(burst_bytes);  // Wraps in 24 bits
			bursts++;
		end
		burst_cnt_o <= bursts;
		err_cnt_o   <= errs;
	end

endmodule

//--- bench/cam_qspi_bridge_tb.sv
/* Bridge testbench: clock, reset, step table, camera driver,
   bus accesses, streamed byte checks and timeout */
`timescale 1ns/1ns

module cam_qspi_bridge_tb;
	import cam_qspi_pkg::*;

	typedef enum logic [1:0] {op_wr, op_rd, op_cam, op_drain} step_kind_e;

	typedef struct packed {
		step_kind_e        kind;
		logic [data_w-1:0] arg;    // Write data, expected status or burst count
		logic [15:0]       n;      // Camera bytes
		logic [3:0]        gap;    // Cycles per byte
		logic              href;
		logic              vsync;
	} step_t;

	localparam int n_steps    = 17;
	localparam int bank_bytes = 4 * burst_bytes;  // Four bursts per bank

	logic              WBs_CLK_i;
	logic              WBs_RST_i;
	logic              wbs_cyc;
	logic              wbs_stb;
	logic              wbs_we;
	logic [data_w-1:0] wbs_wdat;
	logic              wbs_ack;
	logic [data_w-1:0] wbs_rdat;
	logic              cam_stb;
	logic              cam_href;
	logic              cam_vsync;
	logic [7:0]        cam_dat;
	logic              quad_ncs;
	logic [3:0]        quad_dat;
	logic              sram_byte_vld;
	logic [7:0]        sram_byte;
	int                sram_bursts;
	int                sram_errs;

	step_t      steps [n_steps];
	logic [7:0] exp_q [$];           // Gated camera bytes in order
	logic [7:0] exp_byte;
	logic       stream_on      = 1'b0;
	logic       ncs_prev       = 1'b1;
	int         pushed_bytes   = 0;
	int         streamed_bytes = 0;
	int         bursts_started = 0;
	int         exp_bursts     = 0;
	int         err_cnt        = 0;
	int         cycle_cnt      = 0;
	int         cycle_limit    = 1000000;  // Replaced from the table

	cam_qspi_bridge dut_i (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.wbs_cyc_i     (wbs_cyc),
		.wbs_stb_i     (wbs_stb),
		.wbs_we_i      (wbs_we),
		.wbs_dat_i     (wbs_wdat),
		.wbs_ack_o     (wbs_ack),
		.wbs_dat_o     (wbs_rdat),
		.cam_pix_stb_i (cam_stb),
		.cam_href_i    (cam_href),
		.cam_vsync_i   (cam_vsync),
		.cam_dat_i     (cam_dat),
		.quad_ncs_o    (quad_ncs),
		.quad_dat_o    (quad_dat)
	);

	qspi_sram_model sram_i (
		.WBs_CLK_i   (WBs_CLK_i),
		.quad_ncs_i  (quad_ncs),
		.quad_dat_i  (quad_dat),
		.byte_vld_o  (sram_byte_vld),
		.byte_o      (sram_byte),
		.burst_cnt_o (sram_bursts),
		.err_cnt_o   (sram_errs)
	);

	initial begin
		WBs_CLK_i = 1'b0;
		forever #20 WBs_CLK_i = ~WBs_CLK_i;  // 40 ns period
	end

	// Status layout, other bits zero
	function automatic logic [data_w-1:0] status_word(logic vsync, logic bank);
		logic [data_w-1:0] w;
		w                = '0;
		w[sts_vsync_bit] = vsync;
		w[sts_bank_bit]  = bank;
		return w;
	endfunction

	task automatic check_ack(logic exp);
		assert (wbs_ack === exp) else begin
			$display("Fail wbs_ack_o: got %h expected %h", wbs_ack, exp);
			err_cnt++;
		end
	endtask

	task automatic end_access();
		wbs_cyc = 1'b0;  // Drop after ack
		wbs_stb = 1'b0;
		wbs_we  = 1'b0;
		@(negedge WBs_CLK_i);
		check_ack(1'b0);  // Ack lasts one cycle
	endtask

	task automatic write_ctrl(logic [data_w-1:0] data);
		wbs_cyc   = 1'b1;
		wbs_stb   = 1'b1;
		wbs_we    = 1'b1;
		wbs_wdat  = data;
		stream_on = (data[1:0] == ctrl_stream_code);
		@(negedge WBs_CLK_i);
		check_ack(1'b1);
		end_access();
	endtask

	task automatic read_status(logic [data_w-1:0] exp);
		wbs_cyc = 1'b1;
		wbs_stb = 1'b1;
		wbs_we  = 1'b0;
		@(negedge WBs_CLK_i);
		check_ack(1'b1);
		assert (wbs_rdat === exp) else begin
			$display("Fail wbs_dat_o: got %h expected %h", wbs_rdat, exp);
			err_cnt++;
		end
		end_access();
	endtask

	// --------------------
	// Camera bytes, one strobe per gap cycles
	task automatic feed_camera(int n, int gap, logic href, logic vsync);
		logic [7:0] b;
		cam_href  = href;
		cam_vsync = vsync;
		for (int i = 0; i < n; i++) begin
			b       = 8'($urandom);
			cam_dat = b;
			cam_stb = 1'b1;
			if (href && vsync) begin
				exp_q.push_back(b);  // Only gated bytes reach the SRAM
				pushed_bytes++;
			end
			@(negedge WBs_CLK_i);
			cam_stb = 1'b0;
			repeat (gap - 1) @(negedge WBs_CLK_i);
		end
	endtask

	task automatic wait_bursts(int count);
		while (sram_bursts < count) begin
			@(negedge WBs_CLK_i);
		end
	endtask

	initial begin
		void'($urandom(32'h66ee));
		WBs_RST_i = 1'b1;
		wbs_cyc   = 1'b0;
		wbs_stb   = 1'b0;
		wbs_we    = 1'b0;
		wbs_wdat  = '0;
		cam_stb   = 1'b0;
		cam_href  = 1'b0;
		cam_vsync = 1'b0;
		cam_dat   = '0;
		steps = '{
			'{op_rd,    status_word(1'b0, 1'b0), 16'd0,    4'd0, 1'b0, 1'b0},
			'{op_cam,   32'h0,                   16'd0,    4'd0, 1'b0, 1'b1},
			'{op_rd,    status_word(1'b1, 1'b0), 16'd0,    4'd0, 1'b0, 1'b0},
			'{op_wr,    32'h0,                   16'd0,    4'd0, 1'b0, 1'b0},
			'{op_cam,   32'h0,                   16'd40,   4'd4, 1'b0, 1'b1},  // HREF low
			'{op_cam,   32'h0,                   16'd12,   4'd4, 1'b1, 1'b0},  // VSYNC low
			'{op_cam,   32'h0,                   16'd2100, 4'd4, 1'b1, 1'b1},  // Past bank 0
			'{op_rd,    status_word(1'b1, 1'b1), 16'd0,    4'd0, 1'b0, 1'b0},
			'{op_wr,    32'h0000_0002,           16'd0,    4'd0, 1'b0, 1'b0},  // Stream on
			'{op_cam,   32'h0,                   16'd20,   4'd4, 1'b1, 1'b0},
			'{op_cam,   32'h0,                   16'd1980, 4'd4, 1'b1, 1'b1},
			'{op_cam,   32'h0,                   16'd16,   4'd4, 1'b0, 1'b1},
			'{op_cam,   32'h0,                   16'd40,   4'd4, 1'b1, 1'b1},  // Into bank 0
			'{op_drain, 32'd8,                   16'd0,    4'd0, 1'b0, 1'b0},
			'{op_rd,    status_word(1'b1, 1'b0), 16'd0,    4'd0, 1'b0, 1'b0},
			'{op_cam,   32'h0,                   16'd0,    4'd0, 1'b0, 1'b0},
			'{op_rd,    status_word(1'b0, 1'b0), 16'd0,    4'd0, 1'b0, 1'b0}
		};
		cycle_limit = 10 + 2 * 4200;  // Reset plus two bank drains
		foreach (steps[i]) begin
			cycle_limit += int'(steps[i].n) * int'(steps[i].gap) + 4;
		end
		cycle_limit = cycle_limit * 5 / 4;
		repeat (10) @(negedge WBs_CLK_i);
		WBs_RST_i = 1'b0;
		@(negedge WBs_CLK_i);
		assert (quad_ncs === 1'b1) else begin
			$display("Fail quad_ncs_o: got %h expected %h", quad_ncs, 1'b1);
			err_cnt++;
		end
		foreach (steps[i]) begin
			case (steps[i].kind)
				op_wr:   write_ctrl(steps[i].arg);
				op_rd:   read_status(steps[i].arg);
				op_cam:  feed_camera(int'(steps[i].n), int'(steps[i].gap),
				                     steps[i].href, steps[i].vsync);
				default: wait_bursts(int'(steps[i].arg));
			endcase
		end
		// --------------------
		// Whole banks only, four bursts each
		exp_bursts = (pushed_bytes / bank_bytes) * (bank_bytes / burst_bytes);
		assert (sram_bursts == exp_bursts) else begin
			$display("Fail quad_ncs_o bursts: got %h expected %h", sram_bursts, exp_bursts);
			err_cnt++;
		end
		assert (streamed_bytes == exp_bursts * burst_bytes) else begin
			$display("Fail quad_dat_o bytes: got %h expected %h", streamed_bytes,
			         exp_bursts * burst_bytes);
			err_cnt++;
		end
		$display("Errors: bench %0d, sram model %0d", err_cnt, sram_errs);
		if (err_cnt + sram_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Compare each streamed byte with the oldest gated camera byte
	always @(posedge WBs_CLK_i) begin
		if (sram_byte_vld === 1'b1) begin
			assert (exp_q.size() != 0) else begin
				$display("Streamed byte %0d arrived with no camera byte pending", streamed_bytes);
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				exp_byte = exp_q.pop_front();
				assert (sram_byte == exp_byte) else begin
					$display("Fail quad_dat_o byte %0d: got %h expected %h", streamed_bytes,
					         sram_byte, exp_byte);
					err_cnt++;
				end
			end
			streamed_bytes++;
		end
	end

	// Burst start needs streaming on and its bank filled
	always @(negedge WBs_CLK_i) begin
		if (ncs_prev && quad_ncs === 1'b0) begin
			assert (stream_on) else begin
				$display("QSPI select went low while streaming was disabled");
				err_cnt++;
			end
			assert (pushed_bytes >= (bursts_started / 4 + 1) * bank_bytes) else begin
				$display("Burst %0d started before its bank was filled", bursts_started);
				err_cnt++;
			end
			bursts_started++;
		end
		ncs_prev = (quad_ncs !== 1'b0);
	end

	always @(posedge WBs_CLK_i) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: run exceeded %0d cycles with %0d bursts seen", cycle_limit,
			         sram_bursts);
			$display("Errors: bench %0d, sram model %0d", err_cnt, sram_errs);
			$display("sim failed");
			$finish;
		end
	end

endmodule

//--- cam_qspi_bridge.f
logic/cam_qspi_pkg.sv
logic/bank_ram.sv
logic/frame_buffer.sv
logic/cam_pixel_packer.sv
logic/qspi_burst_writer.sv
logic/wb_ctrl_regs.sv
logic/cam_qspi_bridge.sv
bench/qspi_sram_model.sv
bench/cam_qspi_bridge_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cam_qspi_bridge_tb
FLIST     = cam_qspi_bridge.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
